// ==== tests/cpu_stim.txt ====
# Each test opens with test <name> <cycle limit> and closes with end
# Records are w <byte addr> <word> and rnd <byte addr> <LCG word count>
# Expected results are r <reg> <value> and m <byte addr> <value>
test imm_ops 80
w 00 123450b7  w 04 00001117  w 08 ffb00193  w 0c 0011a213
w 10 0011b293  w 14 4011d313  w 18 0011d393  w 1c 0ff0c413
w 20 0f047493  w 24 00449513  w 28 00a56593  w 2c 0000006f
r 1 12345000  r 2 00001004  r 3 fffffffb  r 4 00000001
r 5 00000000  r 6 fffffffd  r 7 7ffffffd  r 8 123450ff
r 9 000000f0  r 10 00000f00  r 11 00000f0a
end
test reg_ops 80
w 00 ff800093  w 04 00300113  w 08 002081b3  w 0c 40208233
w 10 0020a2b3  w 14 0020b333  w 18 4020d3b3  w 1c 0020d433
w 20 002114b3  w 24 0020e533  w 28 0020f5b3  w 2c 00208033
w 30 00112633  w 34 001136b3  w 38 0000006f
r 0 00000000  r 1 fffffff8  r 2 00000003  r 3 fffffffb
r 4 fffffff5  r 5 00000001  r 6 00000000  r 7 ffffffff
r 8 1fffffff  r 9 00000018  r 10 fffffffb  r 11 00000000
r 12 00000000  r 13 00000001
end
# Branches on x1 = 5 and x2 = -3 with x31 set only on a wrong path
test branches 100
w 00 00500093  w 04 ffd00113  w 08 00108463  w 0c 00100f93
w 10 00208463  w 14 00150513  w 18 00209463  w 1c 00200f93
w 20 00109463  w 24 00150513  w 28 00114463  w 2c 00300f93
w 30 0020c463  w 34 00150513  w 38 0020d463  w 3c 00400f93
w 40 00115463  w 44 00150513  w 48 0020e463  w 4c 00500f93
w 50 00116463  w 54 00150513  w 58 00117463  w 5c 00600f93
w 60 0020f463  w 64 00150513  w 68 0000006f
r 1 00000005  r 2 fffffffd  r 10 00000006  r 31 00000000
end
test jumps 60
w 00 00c000ef  w 04 00100f93  w 08 00200f93  w 0c 01c00293
w 10 00428167  w 14 00300f93  w 18 00400f93  w 1c 00500f93
w 20 00700313  w 24 0000006f
r 1 00000004  r 2 00000014  r 5 0000001c  r 6 00000007
r 31 00000000
end
test load_store 80
w 00 a5a5a0b7  w 04 5a508093  w 08 20000113  w 0c 00112023
w 10 00212223  w 14 00012183  w 18 00412203  w 1c 004182b3
w 20 00512423  w 24 0000006f
r 1 a5a5a5a5  r 2 00000200  r 3 a5a5a5a5  r 4 00000200
r 5 a5a5a7a5
m 200 a5a5a5a5  m 204 00000200  m 208 a5a5a7a5
end
# Operands are the first four LCG words from seed 81 (x * 65537 + 0x12345679)
test lcg_add_xor 100
rnd 300 4
w 00 30000493  w 04 0004a083  w 08 0044a103  w 0c 0084a183
w 10 00c4a203  w 14 002082b3  w 18 0020c333  w 1c 004183b3
w 20 0041c433  w 24 0054a823  w 28 0084aa23  w 2c 0000006f
r 1 128556ca  r 2 7b83ad43  r 3 3afb03bc  r 4 50eb5a35
r 5 8e09040d  r 6 6906fb89  r 7 8be65df1  r 8 6a105989
r 9 00000300
m 300 128556ca  m 310 8e09040d  m 314 6a105989
end

// ==== files.f ====
common/rv32i_pkg.sv
logic/alu.sv
logic/regfile.sv
core/cpu_control.sv
core/cpu_datapath.sv
logic/mem_arbiter.sv
logic/unified_mem.sv
logic/cpu_top.sv
tests/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - common/rv32i_pkg.sv
  - logic/alu.sv
  - logic/regfile.sv
  - core/cpu_control.sv
  - core/cpu_datapath.sv
  - logic/mem_arbiter.sv
  - logic/unified_mem.sv
  - logic/cpu_top.sv
  - target: simulation
    files:
      - tests/cpu_tb.sv

// ==== tests/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_tb import rv32i_pkg::*; ();

	localparam int MEM_WORDS_LOG2 = 8;
	localparam int RESET_CYCLES = 10;
	localparam string STIM_PATH = "tests/cpu_stim.txt";

	logic clk;
	logic rst_n;
	logic run;
	logic load_req;
	logic load_we;
	logic [MEM_WORDS_LOG2-1:0] load_addr;
	word_t load_wdata;
	logic load_gnt;
	logic load_rvalid;
	word_t load_rdata;
	logic halted;
	reg_idx_t dbg_idx;
	word_t dbg_data;

	int cycle_count = 0;
	int cycle_budget = RESET_CYCLES + 20;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	word_t lcg_state;
	logic [255:0] test_name;

	reg_idx_t exp_reg_idx[$];
	word_t exp_reg_val[$];
	addr_t exp_mem_addr[$];
	word_t exp_mem_val[$];

	cpu_top #(
		.MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
	) i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.run         (run),
		.load_req    (load_req),
		.load_we     (load_we),
		.load_addr   (load_addr),
		.load_wdata  (load_wdata),
		.load_gnt    (load_gnt),
		.load_rvalid (load_rvalid),
		.load_rdata  (load_rdata),
		.halted      (halted),
		.dbg_idx     (dbg_idx),
		.dbg_data    (dbg_data)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Budget grows as the stim records are read
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_budget) begin
			$display("timeout: run stopped after %0d cycles", cycle_count);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic word_t lcg_next(input word_t state);
		return state * 32'd65537 + 32'h12345679;
	endfunction

	task automatic check_reg(input reg_idx_t idx, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("mismatch in %0s: x%0d expected %h actual %h",
				test_name, idx, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_mem(input addr_t addr, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("mismatch in %0s: mem[%h] expected %h actual %h",
				test_name, addr, expected, actual);
			error_count++;
		end
	endtask

	task automatic write_word(input addr_t byte_addr, input word_t data);
		@(negedge clk);
		load_req = 1'b1;
		load_we = 1'b1;
		load_addr = byte_addr[MEM_WORDS_LOG2+1:2];
		load_wdata = data;
		do
			@(posedge clk);
		while (!load_gnt);
		@(negedge clk);
		load_req = 1'b0;
		load_we = 1'b0;
		// A write is done at its grant
		if (load_rvalid) begin
			$display("%0s: write to mem[%h] returned a read valid", test_name, byte_addr);
			error_count++;
		end
	endtask

	task automatic read_word(input addr_t byte_addr, output word_t data);
		@(negedge clk);
		load_req = 1'b1;
		load_we = 1'b0;
		load_addr = byte_addr[MEM_WORDS_LOG2+1:2];
		do
			@(posedge clk);
		while (!load_gnt);
		@(negedge clk);
		load_req = 1'b0;
		// Read data is due one cycle after the grant
		if (!load_rvalid) begin
			$display("%0s: no read valid one cycle after the grant of mem[%h]",
				test_name, byte_addr);
			error_count++;
		end
		data = load_rdata;
	endtask

	// Clears registers and pc but keeps memory
	task automatic pulse_reset(input int cycles);
		@(negedge clk);
		rst_n = 1'b0;
		repeat (cycles) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic run_test(input int fd, input int limit);
		logic [255:0] tok;
		logic [1023:0] line;
		addr_t addr;
		word_t data;
		word_t actual;
		int idx;
		int count;
		int code;
		int waited;
		int errors_before;
		logic done;

		errors_before = error_count;
		exp_reg_idx.delete();
		exp_reg_val.delete();
		exp_mem_addr.delete();
		exp_mem_val.delete();
		cycle_budget += limit + 40;
		done = 1'b0;

		while (!done) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) begin
				$display("stim file ended inside test %0s", test_name);
				error_count++;
				done = 1'b1;
			end else if (tok == "#") begin
				code = $fgets(line, fd);
			end else if (tok == "w") begin
				code = $fscanf(fd, "%h %h", addr, data);
				cycle_budget += 4;
				write_word(addr, data);
			end else if (tok == "rnd") begin
				code = $fscanf(fd, "%h %d", addr, count);
				for (int k = 0; k < count; k++) begin
					lcg_state = lcg_next(lcg_state);
					cycle_budget += 4;
					write_word(addr + 4 * k, lcg_state);
				end
			end else if (tok == "r") begin
				code = $fscanf(fd, "%d %h", idx, data);
				cycle_budget += 4;
				exp_reg_idx.push_back(reg_idx_t'(idx));
				exp_reg_val.push_back(data);
			end else if (tok == "m") begin
				code = $fscanf(fd, "%h %h", addr, data);
				cycle_budget += 4;
				exp_mem_addr.push_back(addr);
				exp_mem_val.push_back(data);
			end else if (tok == "end") begin
				done = 1'b1;
			end else begin
				$display("unknown record %0s in test %0s", tok, test_name);
				error_count++;
			end
		end

		@(negedge clk);
		run = 1'b1;
		waited = 0;
		while (!halted && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (!halted) begin
			$display("%0s: program did not halt within %0d cycles", test_name, limit);
			error_count++;
		end

		// Registers are lost at the reset pulse and are read first
		foreach (exp_reg_idx[i]) begin
			@(negedge clk);
			dbg_idx = exp_reg_idx[i];
			@(negedge clk);
			check_reg(exp_reg_idx[i], exp_reg_val[i], dbg_data);
		end
		run = 1'b0;
		pulse_reset(2);

		foreach (exp_mem_addr[i]) begin
			read_word(exp_mem_addr[i], actual);
			check_mem(exp_mem_addr[i], exp_mem_val[i], actual);
		end

		tests_run++;
		if (error_count == errors_before) begin
			$display("test %0s passed, halted after %0d cycles", test_name, waited);
		end else begin
			tests_failed++;
			$display("test %0s failed with %0d errors", test_name, error_count - errors_before);
		end
	endtask

	initial begin
		logic [255:0] tok;
		logic [1023:0] line;
		int fd;
		int limit;
		int code;

		rst_n = 1'b0;
		run = 1'b0;
		load_req = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_wdata = '0;
		dbg_idx = '0;
		lcg_state = 32'd81;
		test_name = "none";

		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		fd = $fopen(STIM_PATH, "r");
		if (fd == 0) begin
			$display("cannot open stim file %0s", STIM_PATH);
			$display("Test FAILED");
			$finish;
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					code = $fgets(line, fd);
				end else if (tok == "test") begin
					code = $fscanf(fd, "%s %d", test_name, limit);
					run_test(fd, limit);
				end else begin
					$display("unknown record %0s in stim file", tok);
					error_count++;
				end
			end
			$fclose(fd);

			$display("%0d tests run, %0d passed, %0d failed, %0d errors",
				tests_run, tests_run - tests_failed, tests_failed, error_count);
			if (error_count == 0 && tests_run > 0)
				$display("Test OK");
			else
				$display("Test FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top import rv32i_pkg::*; #(
	parameter int MEM_WORDS_LOG2 = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  logic load_req,
	input  logic load_we,
	input  logic [MEM_WORDS_LOG2-1:0] load_addr,
	input  word_t load_wdata,
	output logic load_gnt,
	output logic load_rvalid,
	output word_t load_rdata,
	output logic halted,
	input  reg_idx_t dbg_idx,
	output word_t dbg_data
);

	logic core_req;
	logic core_we;
	logic [MEM_WORDS_LOG2-1:0] core_addr;
	word_t core_wdata;
	logic core_gnt;
	logic core_rvalid;
	word_t core_rdata;
	logic mem_en;
	logic mem_we;
	logic [MEM_WORDS_LOG2-1:0] mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;

	cpu_datapath #(
		.MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
	) i_core (
		.clk         (clk),
		.rst_n       (rst_n),
		.run         (run),
		.core_req    (core_req),
		.core_we     (core_we),
		.core_addr   (core_addr),
		.core_wdata  (core_wdata),
		.core_gnt    (core_gnt),
		.core_rvalid (core_rvalid),
		.core_rdata  (core_rdata),
		.halted      (halted),
		.dbg_idx     (dbg_idx),
		.dbg_data    (dbg_data)
	);

	mem_arbiter #(
		.MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
	) i_arbiter (
		.clk         (clk),
		.rst_n       (rst_n),
		.load_req    (load_req),
		.load_we     (load_we),
		.load_addr   (load_addr),
		.load_wdata  (load_wdata),
		.load_gnt    (load_gnt),
		.load_rvalid (load_rvalid),
		.load_rdata  (load_rdata),
		.core_req    (core_req),
		.core_we     (core_we),
		.core_addr   (core_addr),
		.core_wdata  (core_wdata),
		.core_gnt    (core_gnt),
		.core_rvalid (core_rvalid),
		.core_rdata  (core_rdata),
		.mem_en      (mem_en),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_rdata   (mem_rdata)
	);

	unified_mem #(
		.MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
	) i_mem (
		.clk   (clk),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== logic/unified_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module unified_mem import rv32i_pkg::*; #(
	parameter int MEM_WORDS_LOG2 = 8
) (
	input  logic clk,
	input  logic en,
	input  logic we,
	input  logic [MEM_WORDS_LOG2-1:0] addr,
	input  word_t wdata,
	output word_t rdata
);

	word_t mem [2**MEM_WORDS_LOG2];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import rv32i_pkg::*; #(
	parameter int MEM_WORDS_LOG2 = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic load_req,
	input  logic load_we,
	input  logic [MEM_WORDS_LOG2-1:0] load_addr,
	input  word_t load_wdata,
	output logic load_gnt,
	output logic load_rvalid,
	output word_t load_rdata,
	input  logic core_req,
	input  logic core_we,
	input  logic [MEM_WORDS_LOG2-1:0] core_addr,
	input  word_t core_wdata,
	output logic core_gnt,
	output logic core_rvalid,
	output word_t core_rdata,
	output logic mem_en,
	output logic mem_we,
	output logic [MEM_WORDS_LOG2-1:0] mem_addr,
	output word_t mem_wdata,
	input  word_t mem_rdata
);

	logic load_rd_q;
	logic core_rd_q;

	// Load port always wins
	assign load_gnt = load_req;
	assign core_gnt = core_req && !load_req;

	assign mem_en = load_req || core_req;
	assign mem_we = load_req ? load_we : core_we;
	assign mem_addr = load_req ? load_addr : core_addr;
	assign mem_wdata = load_req ? load_wdata : core_wdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_rd_q <= 1'b0;
			core_rd_q <= 1'b0;
		end else begin
			load_rd_q <= load_gnt && !load_we;
			core_rd_q <= core_gnt && !core_we;
		end
	end

	assign load_rvalid = load_rd_q;
	assign core_rvalid = core_rd_q;
	assign load_rdata = mem_rdata;
	assign core_rdata = mem_rdata;

	// Core port keeps its request and write payload until granted
	assert property (@(posedge clk) disable iff (!rst_n)
		(core_req && !core_gnt) |=> core_req && $stable(core_we) && $stable(core_wdata));

endmodule

`default_nettype wire

// ==== core/cpu_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_datapath import rv32i_pkg::*; #(
	parameter int MEM_WORDS_LOG2 = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	output logic core_req,
	output logic core_we,
	output logic [MEM_WORDS_LOG2-1:0] core_addr,
	output word_t core_wdata,
	input  logic core_gnt,
	input  logic core_rvalid,
	input  word_t core_rdata,
	output logic halted,
	input  reg_idx_t dbg_idx,
	output word_t dbg_data
);

	core_state_t state;
	addr_t pc;
	addr_t pc_plus4;
	addr_t br_target;
	addr_t pc_next;
	word_t ir;
	logic data_gnt_q;
	rv32i_control_word cword;
	word_t rs1_data;
	word_t rs2_data;
	word_t i_imm;
	word_t s_imm;
	word_t b_imm;
	word_t u_imm;
	word_t j_imm;
	word_t alu_a;
	word_t alu_b;
	word_t cmp_b;
	word_t alu_result;
	logic cmp_true;
	logic rf_we;
	word_t rf_wdata;
	logic self_jal;

	cpu_control i_control (
		.opcode (rv32i_opcode'(ir[6:0])),
		.funct3 (ir[14:12]),
		.funct7 (ir[31:25]),
		.rd     (ir[11:7]),
		.rs1_in (ir[19:15]),
		.rs2_in (ir[24:20]),
		.cword  (cword)
	);

	regfile i_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.we       (rf_we),
		.waddr    (cword.rd),
		.wdata    (rf_wdata),
		.raddr1   (cword.rs1),
		.raddr2   (cword.rs2),
		.dbg_idx  (dbg_idx),
		.rdata1   (rs1_data),
		.rdata2   (rs2_data),
		.dbg_data (dbg_data)
	);

	alu i_alu (
		.aluop    (cword.aluop),
		.cmpop    (cword.cmpop),
		.a        (alu_a),
		.b        (alu_b),
		.cmp_b    (cmp_b),
		.result   (alu_result),
		.cmp_true (cmp_true)
	);

	assign i_imm = {{21{ir[31]}}, ir[30:20]};
	assign s_imm = {{21{ir[31]}}, ir[30:25], ir[11:7]};
	assign b_imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
	assign u_imm = {ir[31:12], 12'h000};
	assign j_imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

	assign alu_a = cword.alumux1_sel ? pc : rs1_data;
	assign cmp_b = cword.cmpmux_sel ? i_imm : rs2_data;

	always_comb begin
		case (cword.alumux2_sel)
			3'd1: alu_b = u_imm;
			3'd3: alu_b = s_imm;
			3'd4: alu_b = rs2_data;
			3'd5: alu_b = j_imm;
			default: alu_b = i_imm;
		endcase
	end

	always_comb begin
		case (cword.memwbmux_sel)
			3'd1: rf_wdata = {31'b0, cmp_true};
			3'd2: rf_wdata = u_imm;
			3'd3: rf_wdata = core_rdata;
			3'd4: rf_wdata = pc_plus4;
			default: rf_wdata = alu_result;
		endcase
	end

	assign pc_plus4 = pc + 32'd4;
	assign br_target = pc + b_imm;
	// Jump target with bit 0 cleared for jalr
	assign pc_next = cword.jump ? {alu_result[31:1], 1'b0} :
		(cword.branch && cmp_true) ? br_target : pc_plus4;
	assign self_jal = (cword.opcode == op_jal) && (alu_result == pc);

	// Loads write back on rvalid and the rest in EXECUTE
	assign rf_we = (state == EXECUTE && cword.load_regfile && !cword.mem_read) ||
		(state == MEM_WAIT && data_gnt_q && core_rvalid);

	assign core_req = (state == FETCH && run) || (state == MEM_WAIT && !data_gnt_q);
	assign core_we = (state == MEM_WAIT) && cword.mem_write;
	assign core_addr = (state == MEM_WAIT) ? alu_result[MEM_WORDS_LOG2+1:2] :
		pc[MEM_WORDS_LOG2+1:2];
	assign core_wdata = rs2_data;
	assign halted = (state == HALT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FETCH;
			pc <= '0;
			data_gnt_q <= 1'b0;
		end else begin
			case (state)
				FETCH: begin
					if (core_gnt)
						state <= FETCH_WAIT;
				end
				FETCH_WAIT: begin
					if (core_rvalid)
						state <= EXECUTE;
				end
				EXECUTE: begin
					pc <= pc_next;
					if (self_jal)
						state <= HALT;
					else if (cword.mem_read || cword.mem_write)
						state <= MEM_WAIT;
					else
						state <= FETCH;
				end
				MEM_WAIT: begin
					if (core_gnt && cword.mem_write) begin
						state <= FETCH;
					end else if (core_gnt) begin
						data_gnt_q <= 1'b1;
					end else if (data_gnt_q && core_rvalid) begin
						data_gnt_q <= 1'b0;
						state <= FETCH;
					end
				end
				HALT: ;
				default: state <= FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH_WAIT && core_rvalid)
			ir <= core_rdata;
	end

	// Read data only arrives while the core waits for it
	assert property (@(posedge clk) disable iff (!rst_n)
		core_rvalid |-> (state == FETCH_WAIT || (state == MEM_WAIT && data_gnt_q)));

	// Requester side of the handshake
	assert property (@(posedge clk) disable iff (!rst_n)
		(core_req && !core_gnt) |=> $stable(core_addr));

endmodule

`default_nettype wire

// ==== core/cpu_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_control import rv32i_pkg::*; (
	input  rv32i_opcode opcode,
	input  logic [2:0] funct3,
	input  logic [6:0] funct7,
	input  reg_idx_t rd,
	input  reg_idx_t rs1_in,
	input  reg_idx_t rs2_in,
	output rv32i_control_word cword
);

	arith_funct3_t arith_funct3;

	assign arith_funct3 = arith_funct3_t'(funct3);

	always_comb begin
		// Defaults, overridden per opcode below
		cword.opcode = opcode;
		cword.aluop = alu_add;
		cword.cmpop = branch_funct3_t'(funct3);
		cword.funct3 = funct3;
		cword.rd = rd;
		cword.rs1 = rs1_in;
		cword.rs2 = rs2_in;
		cword.load_regfile = 1'b0;
		cword.mem_read = 1'b0;
		cword.mem_write = 1'b0;
		cword.jump = 1'b0;
		cword.branch = 1'b0;
		cword.cmpmux_sel = 1'b0;
		cword.alumux1_sel = 1'b0;
		cword.alumux2_sel = 3'd0;
		cword.memwbmux_sel = 3'd0;

		case (opcode)
			op_lui: begin
				cword.load_regfile = 1'b1;
				cword.memwbmux_sel = 3'd2;
				cword.rs1 = '0;
				cword.rs2 = '0;
			end
			op_auipc: begin
				cword.load_regfile = 1'b1;
				cword.alumux1_sel = 1'b1;
				cword.alumux2_sel = 3'd1;
				cword.rs1 = '0;
				cword.rs2 = '0;
			end
			op_jal: begin
				cword.load_regfile = 1'b1;
				cword.memwbmux_sel = 3'd4;
				cword.alumux1_sel = 1'b1;
				cword.alumux2_sel = 3'd5;
				cword.jump = 1'b1;
				cword.rs1 = '0;
				cword.rs2 = '0;
			end
			op_jalr: begin
				cword.load_regfile = 1'b1;
				cword.memwbmux_sel = 3'd4;
				cword.jump = 1'b1;
				cword.rs2 = '0;
			end
			// Compare rs1 with rs2, target adder lives in the datapath
			op_br: begin
				cword.branch = 1'b1;
				cword.rd = '0;
			end
			op_load: begin
				cword.load_regfile = 1'b1;
				cword.mem_read = 1'b1;
				cword.memwbmux_sel = 3'd3;
				cword.rs2 = '0;
			end
			op_store: begin
				cword.mem_write = 1'b1;
				cword.alumux2_sel = 3'd3;
				cword.rd = '0;
			end
			op_imm: begin
				cword.load_regfile = 1'b1;
				cword.aluop = alu_ops'(funct3);
				cword.rs2 = '0;
				case (arith_funct3)
					slt: begin
						cword.cmpop = blt;
						cword.cmpmux_sel = 1'b1;
						cword.memwbmux_sel = 3'd1;
					end
					sltu: begin
						cword.cmpop = bltu;
						cword.cmpmux_sel = 1'b1;
						cword.memwbmux_sel = 3'd1;
					end
					sr: begin
						cword.aluop = funct7[5] ? alu_sra : alu_srl;
					end
					default: ;
				endcase
			end
			op_reg: begin
				cword.load_regfile = 1'b1;
				cword.alumux2_sel = 3'd4;
				cword.aluop = alu_ops'(funct3);
				case (arith_funct3)
					add: begin
						if (funct7[5])
							cword.aluop = alu_sub;
					end
					slt: begin
						cword.cmpop = blt;
						cword.memwbmux_sel = 3'd1;
					end
					sltu: begin
						cword.cmpop = bltu;
						cword.memwbmux_sel = 3'd1;
					end
					sr: begin
						cword.aluop = funct7[5] ? alu_sra : alu_srl;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile import rv32i_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic we,
	input  reg_idx_t waddr,
	input  word_t wdata,
	input  reg_idx_t raddr1,
	input  reg_idx_t raddr2,
	input  reg_idx_t dbg_idx,
	output word_t rdata1,
	output word_t rdata2,
	output word_t dbg_data
);

	word_t regs [32];

	// x0 is cleared by reset and never written
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			regs <= '{default: '0};
		else if (we && waddr != '0)
			regs[waddr] <= wdata;
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];
	assign dbg_data = regs[dbg_idx];

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu import rv32i_pkg::*; (
	input  alu_ops aluop,
	input  branch_funct3_t cmpop,
	input  word_t a,
	input  word_t b,
	input  word_t cmp_b,
	output word_t result,
	output logic cmp_true
);

	always_comb begin
		case (aluop)
			alu_add: result = a + b;
			alu_sll: result = a << b[4:0];
			alu_sra: result = $signed(a) >>> b[4:0];
			alu_sub: result = a - b;
			alu_xor: result = a ^ b;
			alu_srl: result = a >> b[4:0];
			alu_or:  result = a | b;
			alu_and: result = a & b;
			default: result = a + b;
		endcase
	end

	// Shared by branches and slt/sltu
	always_comb begin
		case (cmpop)
			beq:  cmp_true = (a == cmp_b);
			bne:  cmp_true = (a != cmp_b);
			blt:  cmp_true = ($signed(a) < $signed(cmp_b));
			bge:  cmp_true = ($signed(a) >= $signed(cmp_b));
			bltu: cmp_true = (a < cmp_b);
			bgeu: cmp_true = (a >= cmp_b);
			default: cmp_true = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== common/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0] reg_idx_t;

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	typedef enum logic [2:0] {
		add  = 3'b000,
		sll  = 3'b001,
		slt  = 3'b010,
		sltu = 3'b011,
		axor = 3'b100,
		sr   = 3'b101,
		aor  = 3'b110,
		aand = 3'b111
	} arith_funct3_t;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	// Matches funct3 except where sub and sra take the unused slots
	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sra = 3'b010,
		alu_sub = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_ops;

	typedef struct packed {
		rv32i_opcode opcode;
		alu_ops aluop;
		branch_funct3_t cmpop;
		logic [2:0] funct3;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic load_regfile;
		logic mem_read;
		logic mem_write;
		logic jump;
		logic branch;
		logic cmpmux_sel;
		logic alumux1_sel;
		logic [2:0] alumux2_sel;
		logic [2:0] memwbmux_sel;
	} rv32i_control_word;

	typedef enum logic [2:0] {
		FETCH,
		FETCH_WAIT,
		EXECUTE,
		MEM_WAIT,
		HALT
	} core_state_t;

endpackage

`default_nettype wire
